// ==== rtl/iq_pkg.sv ====
package iq_pkg;

  localparam int iq_depth       = 8;
  localparam int iq_idx_w       = 3;
  localparam int iq_count_w     = 4;
  localparam int dispatch_width = 2;
  localparam int phys_tag_w     = 6;
  localparam int rob_addr_w     = 5;
  localparam int operand_w      = 32;

  // passed through to the ALU untouched
  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_slt
  } alu_cmd_e;

  // op2_reg uses the low phys_tag_w bits of op2 as the tag
  typedef enum logic {
    op2_reg,
    op2_imm
  } op2_type_e;

  // any writeback lane producing this tag
  function automatic logic wb_hit(input logic [dispatch_width-1:0] valid,
                                  input logic [dispatch_width-1:0][phys_tag_w-1:0] tag,
                                  input logic [phys_tag_w-1:0] src);
    logic hit;
    hit = 1'b0;
    for (int l = 0; l < dispatch_width; l++) begin
      hit = hit | (valid[l] && tag[l] == src);
    end
    return hit;
  endfunction

endpackage

// ==== rtl/dispatch_intake.sv ====
`timescale 1ns/100ps

module dispatch_intake (
  input  logic [iq_pkg::iq_count_w-1:0]                          count,
  input  logic [iq_pkg::dispatch_width-1:0]                      disp_en,
  input  iq_pkg::alu_cmd_e [iq_pkg::dispatch_width-1:0]          disp_alu_cmd,
  input  logic [iq_pkg::dispatch_width-1:0][iq_pkg::phys_tag_w-1:0] disp_op1_tag,
  input  logic [iq_pkg::dispatch_width-1:0]                      disp_op1_ready,
  input  iq_pkg::op2_type_e [iq_pkg::dispatch_width-1:0]         disp_op2_type,
  input  logic [iq_pkg::dispatch_width-1:0][iq_pkg::operand_w-1:0] disp_op2,
  input  logic [iq_pkg::dispatch_width-1:0]                      disp_op2_ready,
  input  logic [iq_pkg::dispatch_width-1:0][iq_pkg::phys_tag_w-1:0] disp_phys_rd,
  input  logic [iq_pkg::dispatch_width-1:0][iq_pkg::rob_addr_w-1:0] disp_rob_addr,
  input  logic [iq_pkg::dispatch_width-1:0]                      wb_valid,
  input  logic [iq_pkg::dispatch_width-1:0][iq_pkg::phys_tag_w-1:0] wb_tag,
  output logic                                                   full,
  output logic [iq_pkg::dispatch_width-1:0]                      new_valid,
  output iq_pkg::alu_cmd_e [iq_pkg::dispatch_width-1:0]          new_alu_cmd,
  output logic [iq_pkg::dispatch_width-1:0][iq_pkg::phys_tag_w-1:0] new_op1_tag,
  output logic [iq_pkg::dispatch_width-1:0]                      new_op1_ready,
  output iq_pkg::op2_type_e [iq_pkg::dispatch_width-1:0]         new_op2_type,
  output logic [iq_pkg::dispatch_width-1:0][iq_pkg::operand_w-1:0] new_op2,
  output logic [iq_pkg::dispatch_width-1:0]                      new_op2_ready,
  output logic [iq_pkg::dispatch_width-1:0][iq_pkg::phys_tag_w-1:0] new_phys_rd,
  output logic [iq_pkg::dispatch_width-1:0][iq_pkg::rob_addr_w-1:0] new_rob_addr
);

  logic [iq_pkg::dispatch_width-1:0] accept;
  logic [iq_pkg::dispatch_width-1:0] op1_fwd;
  logic [iq_pkg::dispatch_width-1:0] op2_fwd;
  logic                              lone_hi;

  // room for a full pair must remain
  assign full = int'(count) > iq_pkg::iq_depth - iq_pkg::dispatch_width;

  assign accept  = disp_en & {iq_pkg::dispatch_width{~full}};
  assign lone_hi = ~accept[0] & accept[1];

  // same-cycle writeback counts as already ready
  always_comb begin
    for (int l = 0; l < iq_pkg::dispatch_width; l++) begin
      op1_fwd[l] = disp_op1_ready[l] |
                   iq_pkg::wb_hit(wb_valid, wb_tag, disp_op1_tag[l]);
      op2_fwd[l] = (disp_op2_type[l] == iq_pkg::op2_imm) | disp_op2_ready[l] |
                   iq_pkg::wb_hit(wb_valid, wb_tag, disp_op2[l][iq_pkg::phys_tag_w-1:0]);
    end
  end

  // a lone lane 1 is packed into new lane 0
  assign new_valid[0]     = accept[0] | accept[1];
  assign new_alu_cmd[0]   = disp_alu_cmd[lone_hi];
  assign new_op1_tag[0]   = disp_op1_tag[lone_hi];
  assign new_op1_ready[0] = op1_fwd[lone_hi];
  assign new_op2_type[0]  = disp_op2_type[lone_hi];
  assign new_op2[0]       = disp_op2[lone_hi];
  assign new_op2_ready[0] = op2_fwd[lone_hi];
  assign new_phys_rd[0]   = disp_phys_rd[lone_hi];
  assign new_rob_addr[0]  = disp_rob_addr[lone_hi];

  assign new_valid[1]     = accept[0] & accept[1];
  assign new_alu_cmd[1]   = disp_alu_cmd[1];
  assign new_op1_tag[1]   = disp_op1_tag[1];
  assign new_op1_ready[1] = op1_fwd[1];
  assign new_op2_type[1]  = disp_op2_type[1];
  assign new_op2[1]       = disp_op2[1];
  assign new_op2_ready[1] = op2_fwd[1];
  assign new_phys_rd[1]   = disp_phys_rd[1];
  assign new_rob_addr[1]  = disp_rob_addr[1];

endmodule

// ==== rtl/iq_entries.sv ====
`timescale 1ns/100ps

module iq_entries (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  input  logic                                                   flush,
  input  logic [iq_pkg::dispatch_width-1:0]                      new_valid,
  input  iq_pkg::alu_cmd_e [iq_pkg::dispatch_width-1:0]          new_alu_cmd,
  input  logic [iq_pkg::dispatch_width-1:0][iq_pkg::phys_tag_w-1:0] new_op1_tag,
  input  logic [iq_pkg::dispatch_width-1:0]                      new_op1_ready,
  input  iq_pkg::op2_type_e [iq_pkg::dispatch_width-1:0]         new_op2_type,
  input  logic [iq_pkg::dispatch_width-1:0][iq_pkg::operand_w-1:0] new_op2,
  input  logic [iq_pkg::dispatch_width-1:0]                      new_op2_ready,
  input  logic [iq_pkg::dispatch_width-1:0][iq_pkg::phys_tag_w-1:0] new_phys_rd,
  input  logic [iq_pkg::dispatch_width-1:0][iq_pkg::rob_addr_w-1:0] new_rob_addr,
  input  logic [iq_pkg::dispatch_width-1:0]                      wb_valid,
  input  logic [iq_pkg::dispatch_width-1:0][iq_pkg::phys_tag_w-1:0] wb_tag,
  input  logic [iq_pkg::dispatch_width-1:0][iq_pkg::iq_idx_w-1:0] sel_idx,
  input  logic [1:0]                                             sel_count,
  output logic [iq_pkg::iq_count_w-1:0]                          count,
  output logic [iq_pkg::iq_depth-1:0]                            ent_ready,
  output iq_pkg::alu_cmd_e [iq_pkg::iq_depth-1:0]                ent_alu_cmd,
  output logic [iq_pkg::iq_depth-1:0][iq_pkg::phys_tag_w-1:0]    ent_op1_tag,
  output iq_pkg::op2_type_e [iq_pkg::iq_depth-1:0]               ent_op2_type,
  output logic [iq_pkg::iq_depth-1:0][iq_pkg::operand_w-1:0]     ent_op2,
  output logic [iq_pkg::iq_depth-1:0][iq_pkg::phys_tag_w-1:0]    ent_phys_rd,
  output logic [iq_pkg::iq_depth-1:0][iq_pkg::rob_addr_w-1:0]    ent_rob_addr
);

  logic [iq_pkg::iq_depth-1:0]                         ent_valid;
  logic [iq_pkg::iq_depth-1:0]                         picked;
  logic [iq_pkg::iq_depth-1:0]                         ent_op1_ready;
  logic [iq_pkg::iq_depth-1:0]                         ent_op2_ready;
  iq_pkg::alu_cmd_e [iq_pkg::iq_depth-1:0]             nxt_alu_cmd;
  logic [iq_pkg::iq_depth-1:0][iq_pkg::phys_tag_w-1:0] nxt_op1_tag;
  logic [iq_pkg::iq_depth-1:0]                         nxt_op1_ready;
  iq_pkg::op2_type_e [iq_pkg::iq_depth-1:0]            nxt_op2_type;
  logic [iq_pkg::iq_depth-1:0][iq_pkg::operand_w-1:0]  nxt_op2;
  logic [iq_pkg::iq_depth-1:0]                         nxt_op2_ready;
  logic [iq_pkg::iq_depth-1:0][iq_pkg::phys_tag_w-1:0] nxt_phys_rd;
  logic [iq_pkg::iq_depth-1:0][iq_pkg::rob_addr_w-1:0] nxt_rob_addr;
  logic [iq_pkg::iq_idx_w-1:0]                         wr;
  logic [iq_pkg::iq_count_w-1:0]                       count_nxt;

  // entries are packed from slot 0, so valid follows from count
  always_comb begin
    for (int i = 0; i < iq_pkg::iq_depth; i++) begin
      ent_valid[i] = i < int'(count);
      ent_ready[i] = ent_valid[i] & ent_op1_ready[i] & ent_op2_ready[i];
    end
  end

  always_comb begin
    for (int i = 0; i < iq_pkg::iq_depth; i++) begin
      picked[i] = (sel_count != 2'd0 && int'(sel_idx[0]) == i) ||
                  (sel_count == 2'd2 && int'(sel_idx[1]) == i);
    end
  end

  always_comb begin
    nxt_alu_cmd   = ent_alu_cmd;
    nxt_op1_tag   = ent_op1_tag;
    nxt_op1_ready = ent_op1_ready;
    nxt_op2_type  = ent_op2_type;
    nxt_op2       = ent_op2;
    nxt_op2_ready = ent_op2_ready;
    nxt_phys_rd   = ent_phys_rd;
    nxt_rob_addr  = ent_rob_addr;
    wr            = '0;
    count_nxt     = '0;
    // survivors slide down in age order, with wakeup applied on the way
    for (int j = 0; j < iq_pkg::iq_depth; j++) begin
      if (ent_valid[j] && !picked[j]) begin
        nxt_alu_cmd[wr]   = ent_alu_cmd[j];
        nxt_op1_tag[wr]   = ent_op1_tag[j];
        nxt_op1_ready[wr] = ent_op1_ready[j] |
                            iq_pkg::wb_hit(wb_valid, wb_tag, ent_op1_tag[j]);
        nxt_op2_type[wr]  = ent_op2_type[j];
        nxt_op2[wr]       = ent_op2[j];
        nxt_op2_ready[wr] = ent_op2_ready[j] | (ent_op2_type[j] == iq_pkg::op2_reg &&
                            iq_pkg::wb_hit(wb_valid, wb_tag,
                                           ent_op2[j][iq_pkg::phys_tag_w-1:0]));
        nxt_phys_rd[wr]   = ent_phys_rd[j];
        nxt_rob_addr[wr]  = ent_rob_addr[j];
        wr                = wr + 1'b1;
        count_nxt         = count_nxt + 1'b1;
      end
    end
    // new arrivals go behind them, already forwarded
    for (int l = 0; l < iq_pkg::dispatch_width; l++) begin
      if (new_valid[l]) begin
        nxt_alu_cmd[wr]   = new_alu_cmd[l];
        nxt_op1_tag[wr]   = new_op1_tag[l];
        nxt_op1_ready[wr] = new_op1_ready[l];
        nxt_op2_type[wr]  = new_op2_type[l];
        nxt_op2[wr]       = new_op2[l];
        nxt_op2_ready[wr] = new_op2_ready[l];
        nxt_phys_rd[wr]   = new_phys_rd[l];
        nxt_rob_addr[wr]  = new_rob_addr[l];
        wr                = wr + 1'b1;
        count_nxt         = count_nxt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      count <= '0;
    end else begin
      count <= count_nxt;
    end
  end

  always_ff @(posedge clk) begin
    ent_alu_cmd   <= nxt_alu_cmd;
    ent_op1_tag   <= nxt_op1_tag;
    ent_op1_ready <= nxt_op1_ready;
    ent_op2_type  <= nxt_op2_type;
    ent_op2       <= nxt_op2;
    ent_op2_ready <= nxt_op2_ready;
    ent_phys_rd   <= nxt_phys_rd;
    ent_rob_addr  <= nxt_rob_addr;
  end

endmodule

// ==== rtl/oldest_ready_select.sv ====
`timescale 1ns/100ps

module oldest_ready_select (
  input  logic [iq_pkg::iq_depth-1:0]                             ent_ready,
  output logic [iq_pkg::dispatch_width-1:0][iq_pkg::iq_idx_w-1:0] sel_idx,
  output logic [1:0]                                              sel_count
);

  // slot 0 is the oldest, so the first hits win
  always_comb begin
    sel_idx   = '0;
    sel_count = 2'd0;
    for (int i = 0; i < iq_pkg::iq_depth; i++) begin
      if (ent_ready[i] && sel_count != 2'd2) begin
        sel_idx[sel_count[0]] = i[iq_pkg::iq_idx_w-1:0];
        sel_count             = sel_count + 2'd1;
      end
    end
  end

endmodule

// ==== rtl/issue_lanes.sv ====
`timescale 1ns/100ps

module issue_lanes (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  input  logic                                                   flush,
  input  logic [iq_pkg::dispatch_width-1:0][iq_pkg::iq_idx_w-1:0] sel_idx,
  input  logic [1:0]                                             sel_count,
  input  iq_pkg::alu_cmd_e [iq_pkg::iq_depth-1:0]                ent_alu_cmd,
  input  logic [iq_pkg::iq_depth-1:0][iq_pkg::phys_tag_w-1:0]    ent_op1_tag,
  input  iq_pkg::op2_type_e [iq_pkg::iq_depth-1:0]               ent_op2_type,
  input  logic [iq_pkg::iq_depth-1:0][iq_pkg::operand_w-1:0]     ent_op2,
  input  logic [iq_pkg::iq_depth-1:0][iq_pkg::phys_tag_w-1:0]    ent_phys_rd,
  input  logic [iq_pkg::iq_depth-1:0][iq_pkg::rob_addr_w-1:0]    ent_rob_addr,
  output logic [iq_pkg::dispatch_width-1:0]                      issue_valid,
  output iq_pkg::alu_cmd_e [iq_pkg::dispatch_width-1:0]          issue_alu_cmd,
  output logic [iq_pkg::dispatch_width-1:0][iq_pkg::phys_tag_w-1:0] issue_op1_tag,
  output iq_pkg::op2_type_e [iq_pkg::dispatch_width-1:0]         issue_op2_type,
  output logic [iq_pkg::dispatch_width-1:0][iq_pkg::operand_w-1:0] issue_op2,
  output logic [iq_pkg::dispatch_width-1:0][iq_pkg::phys_tag_w-1:0] issue_phys_rd,
  output logic [iq_pkg::dispatch_width-1:0][iq_pkg::rob_addr_w-1:0] issue_rob_addr
);

  // lane 1 only fires alongside lane 0
  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      issue_valid <= '0;
    end else begin
      issue_valid[0] <= sel_count != 2'd0;
      issue_valid[1] <= sel_count == 2'd2;
    end
  end

  always_ff @(posedge clk) begin
    for (int l = 0; l < iq_pkg::dispatch_width; l++) begin
      issue_alu_cmd[l]  <= ent_alu_cmd[sel_idx[l]];
      issue_op1_tag[l]  <= ent_op1_tag[sel_idx[l]];
      issue_op2_type[l] <= ent_op2_type[sel_idx[l]];
      issue_op2[l]      <= ent_op2[sel_idx[l]];
      issue_phys_rd[l]  <= ent_phys_rd[sel_idx[l]];
      issue_rob_addr[l] <= ent_rob_addr[sel_idx[l]];
    end
  end

endmodule

// ==== rtl/issue_queue.sv ====
`timescale 1ns/100ps

module issue_queue (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  input  logic                                                   flush,
  input  logic [iq_pkg::dispatch_width-1:0]                      disp_en,
  input  iq_pkg::alu_cmd_e [iq_pkg::dispatch_width-1:0]          disp_alu_cmd,
  input  logic [iq_pkg::dispatch_width-1:0][iq_pkg::phys_tag_w-1:0] disp_op1_tag,
  input  logic [iq_pkg::dispatch_width-1:0]                      disp_op1_ready,
  input  iq_pkg::op2_type_e [iq_pkg::dispatch_width-1:0]         disp_op2_type,
  input  logic [iq_pkg::dispatch_width-1:0][iq_pkg::operand_w-1:0] disp_op2,
  input  logic [iq_pkg::dispatch_width-1:0]                      disp_op2_ready,
  input  logic [iq_pkg::dispatch_width-1:0][iq_pkg::phys_tag_w-1:0] disp_phys_rd,
  input  logic [iq_pkg::dispatch_width-1:0][iq_pkg::rob_addr_w-1:0] disp_rob_addr,
  output logic                                                   full,
  input  logic [iq_pkg::dispatch_width-1:0]                      wb_valid,
  input  logic [iq_pkg::dispatch_width-1:0][iq_pkg::phys_tag_w-1:0] wb_tag,
  output logic [iq_pkg::dispatch_width-1:0]                      issue_valid,
  output iq_pkg::alu_cmd_e [iq_pkg::dispatch_width-1:0]          issue_alu_cmd,
  output logic [iq_pkg::dispatch_width-1:0][iq_pkg::phys_tag_w-1:0] issue_op1_tag,
  output iq_pkg::op2_type_e [iq_pkg::dispatch_width-1:0]         issue_op2_type,
  output logic [iq_pkg::dispatch_width-1:0][iq_pkg::operand_w-1:0] issue_op2,
  output logic [iq_pkg::dispatch_width-1:0][iq_pkg::phys_tag_w-1:0] issue_phys_rd,
  output logic [iq_pkg::dispatch_width-1:0][iq_pkg::rob_addr_w-1:0] issue_rob_addr
);

  logic [iq_pkg::iq_count_w-1:0]                                count;
  logic [iq_pkg::dispatch_width-1:0]                            new_valid;
  iq_pkg::alu_cmd_e [iq_pkg::dispatch_width-1:0]                new_alu_cmd;
  logic [iq_pkg::dispatch_width-1:0][iq_pkg::phys_tag_w-1:0]    new_op1_tag;
  logic [iq_pkg::dispatch_width-1:0]                            new_op1_ready;
  iq_pkg::op2_type_e [iq_pkg::dispatch_width-1:0]               new_op2_type;
  logic [iq_pkg::dispatch_width-1:0][iq_pkg::operand_w-1:0]     new_op2;
  logic [iq_pkg::dispatch_width-1:0]                            new_op2_ready;
  logic [iq_pkg::dispatch_width-1:0][iq_pkg::phys_tag_w-1:0]    new_phys_rd;
  logic [iq_pkg::dispatch_width-1:0][iq_pkg::rob_addr_w-1:0]    new_rob_addr;
  logic [iq_pkg::iq_depth-1:0]                                  ent_ready;
  iq_pkg::alu_cmd_e [iq_pkg::iq_depth-1:0]                      ent_alu_cmd;
  logic [iq_pkg::iq_depth-1:0][iq_pkg::phys_tag_w-1:0]          ent_op1_tag;
  iq_pkg::op2_type_e [iq_pkg::iq_depth-1:0]                     ent_op2_type;
  logic [iq_pkg::iq_depth-1:0][iq_pkg::operand_w-1:0]           ent_op2;
  logic [iq_pkg::iq_depth-1:0][iq_pkg::phys_tag_w-1:0]          ent_phys_rd;
  logic [iq_pkg::iq_depth-1:0][iq_pkg::rob_addr_w-1:0]          ent_rob_addr;
  logic [iq_pkg::dispatch_width-1:0][iq_pkg::iq_idx_w-1:0]      sel_idx;
  logic [1:0]                                                   sel_count;

  dispatch_intake intake0 (
    .count, .disp_en, .disp_alu_cmd, .disp_op1_tag, .disp_op1_ready, .disp_op2_type,
    .disp_op2, .disp_op2_ready, .disp_phys_rd, .disp_rob_addr, .wb_valid, .wb_tag,
    .full, .new_valid, .new_alu_cmd, .new_op1_tag, .new_op1_ready, .new_op2_type,
    .new_op2, .new_op2_ready, .new_phys_rd, .new_rob_addr
  );

  iq_entries entries0 (
    .clk, .rst_n, .flush, .new_valid, .new_alu_cmd, .new_op1_tag, .new_op1_ready,
    .new_op2_type, .new_op2, .new_op2_ready, .new_phys_rd, .new_rob_addr,
    .wb_valid, .wb_tag, .sel_idx, .sel_count, .count, .ent_ready, .ent_alu_cmd,
    .ent_op1_tag, .ent_op2_type, .ent_op2, .ent_phys_rd, .ent_rob_addr
  );

  oldest_ready_select select0 (
    .ent_ready, .sel_idx, .sel_count
  );

  issue_lanes lanes0 (
    .clk, .rst_n, .flush, .sel_idx, .sel_count, .ent_alu_cmd, .ent_op1_tag,
    .ent_op2_type, .ent_op2, .ent_phys_rd, .ent_rob_addr, .issue_valid,
    .issue_alu_cmd, .issue_op1_tag, .issue_op2_type, .issue_op2, .issue_phys_rd,
    .issue_rob_addr
  );

endmodule

// ==== sim/tb_issue_queue.sv ====
`timescale 1ns/100ps

module tb_issue_queue;

  localparam int reset_cycles = 16;
  localparam int no_instr     = 0;
  // table columns
  localparam int c_wbv   = 2;
  localparam int c_wt0   = 3;
  localparam int c_wt1   = 4;
  localparam int c_fl    = 5;
  localparam int c_full  = 6;
  localparam int c_valid = 7;
  localparam int c_rob0  = 8;

  logic                                                            clk;
  logic                                                            rst_n;
  logic                                                            flush;
  logic [iq_pkg::dispatch_width-1:0]                               disp_en;
  iq_pkg::alu_cmd_e [iq_pkg::dispatch_width-1:0]                   disp_alu_cmd;
  logic [iq_pkg::dispatch_width-1:0][iq_pkg::phys_tag_w-1:0]       disp_op1_tag;
  logic [iq_pkg::dispatch_width-1:0]                               disp_op1_ready;
  iq_pkg::op2_type_e [iq_pkg::dispatch_width-1:0]                  disp_op2_type;
  logic [iq_pkg::dispatch_width-1:0][iq_pkg::operand_w-1:0]        disp_op2;
  logic [iq_pkg::dispatch_width-1:0]                               disp_op2_ready;
  logic [iq_pkg::dispatch_width-1:0][iq_pkg::phys_tag_w-1:0]       disp_phys_rd;
  logic [iq_pkg::dispatch_width-1:0][iq_pkg::rob_addr_w-1:0]       disp_rob_addr;
  logic                                                            full;
  logic [iq_pkg::dispatch_width-1:0]                               wb_valid;
  logic [iq_pkg::dispatch_width-1:0][iq_pkg::phys_tag_w-1:0]       wb_tag;
  logic [iq_pkg::dispatch_width-1:0]                               issue_valid;
  iq_pkg::alu_cmd_e [iq_pkg::dispatch_width-1:0]                   issue_alu_cmd;
  logic [iq_pkg::dispatch_width-1:0][iq_pkg::phys_tag_w-1:0]       issue_op1_tag;
  iq_pkg::op2_type_e [iq_pkg::dispatch_width-1:0]                  issue_op2_type;
  logic [iq_pkg::dispatch_width-1:0][iq_pkg::operand_w-1:0]        issue_op2;
  logic [iq_pkg::dispatch_width-1:0][iq_pkg::phys_tag_w-1:0]       issue_phys_rd;
  logic [iq_pkg::dispatch_width-1:0][iq_pkg::rob_addr_w-1:0]       issue_rob_addr;

  int tbl[64][10];
  int n_rows = 0;
  int cycles = 0;
  int limit  = 1000;

  // what was dispatched under each rob address
  iq_pkg::alu_cmd_e  sent_alu_cmd[32];
  logic [5:0]        sent_op1_tag[32];
  iq_pkg::op2_type_e sent_op2_type[32];
  logic [31:0]       sent_op2[32];

  issue_queue dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("CHECKS FAILED");
      $fatal(1, "run did not finish within %0d cycles", limit);
    end
  end

  // en, rob, op1 tag, op1 ready, op2 is imm, op2 tag, op2 ready
  function automatic int instr(input int rob, input int t1, input int r1,
                               input int imm, input int t2, input int r2);
    return int'({1'b1, 5'(rob), 6'(t1), 1'(r1), 1'(imm), 6'(t2), 1'(r2)});
  endfunction

  function automatic int ready_imm(input int rob);
    return instr(rob, 0, 1, 1, 0, 0);
  endfunction

  function automatic int wait_op1(input int rob, input int tag);
    return instr(rob, tag, 0, 1, 0, 0);
  endfunction

  function automatic logic [31:0] imm_value(input logic [4:0] rob);
    return {16'hc0de, 11'd0, rob};
  endfunction

  task automatic add_row(input int i0, input int i1, input int wbv, input int wt0,
                         input int wt1, input int fl, input int ef, input int ev,
                         input int er0, input int er1);
    tbl[n_rows] = '{i0, i1, wbv, wt0, wt1, fl, ef, ev, er0, er1};
    n_rows = n_rows + 1;
  endtask

  task automatic drive_lane(input int l, input int d);
    logic [20:0] b;
    logic [4:0]  rob;
    logic [31:0] op2;
    b   = 21'(d);
    rob = b[19:15];
    op2 = b[7] ? imm_value(rob) : {26'd0, b[6:1]};
    disp_en[l]        <= b[20];
    disp_alu_cmd[l]   <= iq_pkg::alu_cmd_e'(rob[2:0]);
    disp_op1_tag[l]   <= b[14:9];
    disp_op1_ready[l] <= b[8];
    disp_op2_type[l]  <= b[7] ? iq_pkg::op2_imm : iq_pkg::op2_reg;
    disp_op2[l]       <= op2;
    disp_op2_ready[l] <= b[0];
    disp_phys_rd[l]   <= {1'b1, rob};
    disp_rob_addr[l]  <= rob;
    if (b[20]) begin
      sent_alu_cmd[rob]  = iq_pkg::alu_cmd_e'(rob[2:0]);
      sent_op1_tag[rob]  = b[14:9];
      sent_op2_type[rob] = b[7] ? iq_pkg::op2_imm : iq_pkg::op2_reg;
      sent_op2[rob]      = op2;
    end
  endtask

  task automatic drive_row(input int r);
    drive_lane(0, tbl[r][0]);
    drive_lane(1, tbl[r][1]);
    wb_valid  <= 2'(tbl[r][c_wbv]);
    wb_tag[0] <= 6'(tbl[r][c_wt0]);
    wb_tag[1] <= 6'(tbl[r][c_wt1]);
    flush     <= tbl[r][c_fl] != 0;
  endtask

  task automatic drive_idle();
    drive_lane(0, no_instr);
    drive_lane(1, no_instr);
    wb_valid <= '0;
    wb_tag   <= '0;
    flush    <= 1'b0;
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
      $display("CHECKS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_row(input int r);
    logic [1:0] ev;
    logic [4:0] rob;
    ev = 2'(tbl[r][c_valid]);
    check_value("full", 32'(full), 32'(tbl[r][c_full]));
    for (int l = 0; l < 2; l++) begin
      check_value($sformatf("issue_valid[%0d]", l), 32'(issue_valid[l]), 32'(ev[l]));
      if (ev[l]) begin
        rob = 5'(tbl[r][c_rob0 + l]);
        check_value($sformatf("issue_rob_addr[%0d]", l), 32'(issue_rob_addr[l]), 32'(rob));
        check_value($sformatf("issue_alu_cmd[%0d]", l), 32'(issue_alu_cmd[l]),
                    32'(sent_alu_cmd[rob]));
        check_value($sformatf("issue_op1_tag[%0d]", l), 32'(issue_op1_tag[l]),
                    32'(sent_op1_tag[rob]));
        check_value($sformatf("issue_op2_type[%0d]", l), 32'(issue_op2_type[l]),
                    32'(sent_op2_type[rob]));
        check_value($sformatf("issue_op2[%0d]", l), issue_op2[l], sent_op2[rob]);
        check_value($sformatf("issue_phys_rd[%0d]", l), 32'(issue_phys_rd[l]),
                    32'({1'b1, rob}));
      end
    end
  endtask

  initial begin
    // lane0, lane1, wb_valid, wb_tag0, wb_tag1, flush, full, issue_valid, rob0, rob1
    // expected columns hold the state after the edge that samples the row
    add_row(no_instr, no_instr, 0, 0, 0, 0, 0, 0, 0, 0);
    add_row(ready_imm(1), ready_imm(2), 0, 0, 0, 0, 0, 0, 0, 0);
    add_row(no_instr, no_instr, 0, 0, 0, 0, 0, 3, 1, 2);
    add_row(no_instr, no_instr, 0, 0, 0, 0, 0, 0, 0, 0);
    // wakeup, then forwarding in the dispatch cycle
    add_row(instr(3, 0, 1, 0, 10, 0), no_instr, 0, 0, 0, 0, 0, 0, 0, 0);
    add_row(no_instr, no_instr, 1, 10, 0, 0, 0, 0, 0, 0);
    add_row(no_instr, no_instr, 0, 0, 0, 0, 0, 1, 3, 0);
    add_row(instr(4, 0, 1, 0, 11, 0), wait_op1(5, 12), 3, 11, 12, 0, 0, 0, 0, 0);
    add_row(no_instr, no_instr, 0, 0, 0, 0, 0, 3, 4, 5);
    add_row(no_instr, ready_imm(6), 0, 0, 0, 0, 0, 0, 0, 0);
    add_row(no_instr, no_instr, 0, 0, 0, 0, 0, 1, 6, 0);
    // age order across compaction
    add_row(wait_op1(7, 20), wait_op1(8, 20), 0, 0, 0, 0, 0, 0, 0, 0);
    add_row(wait_op1(9, 20), wait_op1(10, 20), 0, 0, 0, 0, 0, 0, 0, 0);
    add_row(no_instr, no_instr, 1, 20, 0, 0, 0, 0, 0, 0);
    add_row(wait_op1(11, 21), ready_imm(12), 0, 0, 0, 0, 0, 3, 7, 8);
    add_row(wait_op1(13, 21), ready_imm(14), 0, 0, 0, 0, 0, 3, 9, 10);
    add_row(no_instr, no_instr, 0, 0, 0, 0, 0, 3, 12, 14);
    add_row(no_instr, no_instr, 1, 21, 0, 0, 0, 0, 0, 0);
    add_row(no_instr, no_instr, 0, 0, 0, 0, 0, 3, 11, 13);
    add_row(no_instr, no_instr, 0, 0, 0, 0, 0, 0, 0, 0);
    // fill to seven, try dispatch while full, then drain
    add_row(wait_op1(15, 30), wait_op1(16, 31), 0, 0, 0, 0, 0, 0, 0, 0);
    add_row(wait_op1(17, 32), wait_op1(18, 33), 0, 0, 0, 0, 0, 0, 0, 0);
    add_row(wait_op1(19, 34), wait_op1(20, 35), 0, 0, 0, 0, 0, 0, 0, 0);
    add_row(wait_op1(21, 36), no_instr, 0, 0, 0, 0, 1, 0, 0, 0);
    add_row(ready_imm(22), ready_imm(23), 0, 0, 0, 0, 1, 0, 0, 0);
    add_row(ready_imm(24), no_instr, 1, 30, 0, 0, 1, 0, 0, 0);
    add_row(no_instr, no_instr, 1, 31, 0, 0, 0, 1, 15, 0);
    add_row(no_instr, no_instr, 3, 32, 33, 0, 0, 1, 16, 0);
    add_row(no_instr, no_instr, 3, 34, 35, 0, 0, 3, 17, 18);
    add_row(no_instr, no_instr, 1, 36, 0, 0, 0, 3, 19, 20);
    add_row(no_instr, no_instr, 0, 0, 0, 0, 0, 1, 21, 0);
    add_row(no_instr, no_instr, 0, 0, 0, 0, 0, 0, 0, 0);
    // flush drops waiting and ready entries alike
    add_row(wait_op1(25, 40), wait_op1(26, 41), 0, 0, 0, 0, 0, 0, 0, 0);
    add_row(ready_imm(27), ready_imm(28), 0, 0, 0, 0, 0, 0, 0, 0);
    add_row(ready_imm(29), no_instr, 0, 0, 0, 0, 0, 3, 27, 28);
    add_row(no_instr, no_instr, 0, 0, 0, 1, 0, 0, 0, 0);
    add_row(no_instr, no_instr, 3, 40, 41, 0, 0, 0, 0, 0);
    add_row(no_instr, no_instr, 0, 0, 0, 0, 0, 0, 0, 0);
    add_row(ready_imm(30), no_instr, 0, 0, 0, 0, 0, 0, 0, 0);
    add_row(no_instr, no_instr, 0, 0, 0, 0, 0, 1, 30, 0);
    add_row(no_instr, no_instr, 0, 0, 0, 0, 0, 0, 0, 0);
    limit = n_rows + reset_cycles + 20;

    rst_n = 1'b0;
    drive_idle();
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;

    // row r is driven at one edge and checked after the next
    for (int r = 0; r <= n_rows; r++) begin
      @(posedge clk);
      if (r < n_rows) begin
        drive_row(r);
      end else begin
        drive_idle();
      end
      @(negedge clk);
      if (r > 0) begin
        check_row(r - 1);
      end
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== all.f ====
rtl/iq_pkg.sv
rtl/dispatch_intake.sv
rtl/iq_entries.sv
rtl/oldest_ready_select.sv
rtl/issue_lanes.sv
rtl/issue_queue.sv
sim/tb_issue_queue.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, then runs it
# the exit status of the simulation decides pass or fail

cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_issue_queue \
  -f all.f -o tb_issue_queue_sim &&
./obj_dir/tb_issue_queue_sim ||
{
  echo "simulation did not pass"
  exit 1
}
